// File: src/evcnt_defines.svh
// Widths and register offsets of the event-counter peripheral
// Included by the register package, the RTL modules and the testbench
`ifndef EVCNT_DEFINES_SVH
`define EVCNT_DEFINES_SVH

// Register data width in bits
`define EVCNT_DW 32

// Byte address width, large enough to reach the last register at offset 16
`define EVCNT_AW 5

// Byte offsets of the five registers
`define EVCNT_CTRL_OFFSET        0
`define EVCNT_COUNT_OFFSET       4
`define EVCNT_CAPTURE_OFFSET     8
`define EVCNT_INTR_STATE_OFFSET  12
`define EVCNT_INTR_ENABLE_OFFSET 16

`endif

// File: src/prim_subreg_pkg.sv
// Software access types of a generic register slice
// The slice and its write arbiter select their behavior from this type
package prim_subreg_pkg;

  // How software may touch a register slice
  //   RW   read and write, hardware write has priority
  //   RC   a read clears the register
  //   W1C  writing a one clears that bit, a hardware set wins
  typedef enum logic [1:0] {
    SwAccessRW  = 2'd0,
    SwAccessRC  = 2'd1,
    SwAccessW1C = 2'd2
  } sw_access_e;

endpackage

// File: src/evcnt_reg_pkg.sv
// Bus and register interface types of the event-counter peripheral
// Shared by the register block, the counter core and the top level
`include "evcnt_defines.svh"

package evcnt_reg_pkg;

  // One bus access per cycle with req high, no handshake
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [`EVCNT_AW-1:0] addr;
    logic [`EVCNT_DW-1:0] wdata;
  } bus_req_t;

  // Field view of CTRL as the core decodes it
  typedef struct packed {
    logic [`EVCNT_DW-3:0] reserved;
    logic                 capture;
    logic                 enable;
  } ctrl_fields_t;

  // The bus side sees CTRL as a plain word, the core sees the fields
  typedef union packed {
    logic [`EVCNT_DW-1:0] raw;
    ctrl_fields_t         fields;
  } ctrl_u;

  // Register values seen by the core
  typedef struct packed {
    ctrl_u                ctrl;
    logic                 ctrl_qe;
    logic [`EVCNT_DW-1:0] count;
    logic                 intr_state;
  } reg2hw_t;

  // Hardware updates from the core, the INTR_STATE set data is always one
  typedef struct packed {
    logic                 count_de;
    logic [`EVCNT_DW-1:0] count_d;
    logic                 capture_de;
    logic [`EVCNT_DW-1:0] capture_d;
    logic                 intr_de;
  } hw2reg_t;

endpackage

// File: src/prim_subreg_arb.sv
// Write arbiter of one register slice
// Merges the software strobe and the hardware update into one write enable
// and one write value, following the access type of the slice
`timescale 1ns/1ns
`include "evcnt_defines.svh"

module prim_subreg_arb #(
  parameter int                         DW       = `EVCNT_DW,
  parameter prim_subreg_pkg::sw_access_e SwAccess = prim_subreg_pkg::SwAccessRW
) (
  // Software side, for RC the read pulse arrives on we
  input  logic          we,
  input  logic [DW-1:0] wd,
  // Hardware side
  input  logic          de,
  input  logic [DW-1:0] d,
  // Current register value
  input  logic [DW-1:0] q,
  output logic          wr_en,
  output logic [DW-1:0] wr_data
);
  import prim_subreg_pkg::*;

  if (SwAccess == SwAccessRW) begin : gen_rw
    // Either side may write
    assign wr_en   = we | de;
    // Hardware overrides software in the same cycle
    assign wr_data = de ? d : wd;

  end else if (SwAccess == SwAccessW1C) begin : gen_w1c
    logic [DW-1:0] sw_cleared;
    logic [DW-1:0] hw_set;

    // Bits written as one are dropped from the current value
    assign sw_cleared = we ? (q & ~wd) : q;
    // Hardware only ever sets bits
    assign hw_set     = de ? d : '0;

    assign wr_en   = we | de;
    // A set in the same cycle survives the clear
    assign wr_data = sw_cleared | hw_set;

  end else begin : gen_rc
    // A read clears the register, a hardware load alone writes d
    assign wr_en   = we | de;
    assign wr_data = (de && !we) ? d : '0;
  end

endmodule

// File: src/prim_subreg.sv
// Generic register slice with a software access type
// Holds the flop and its reset value, arbitrates software against hardware
// and exposes the current and the next value
`timescale 1ns/1ns
`include "evcnt_defines.svh"

module prim_subreg #(
  parameter int                         DW       = `EVCNT_DW,
  parameter prim_subreg_pkg::sw_access_e SwAccess = prim_subreg_pkg::SwAccessRW,
  parameter logic [DW-1:0]              RESVAL   = '0
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  // Software write strobe and data, the read pulse for RC
  input  logic          we,
  input  logic [DW-1:0] wd,
  // Hardware update strobe and data
  input  logic          de,
  input  logic [DW-1:0] d,
  output logic          qe,
  output logic [DW-1:0] q,
  // Next value of the flop, and the value software reads
  output logic [DW-1:0] ds,
  output logic [DW-1:0] qs
);
  import prim_subreg_pkg::*;

  logic          wr_en;
  logic [DW-1:0] wr_data;

  prim_subreg_arb #(
    .DW       (DW),
    .SwAccess (SwAccess)
  ) i_arb (
    .we      (we),
    .wd      (wd),
    .de      (de),
    .d       (d),
    .q       (q),
    .wr_en   (wr_en),
    .wr_data (wr_data)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      q <= RESVAL;
    end else if (wr_en) begin
      q <= wr_data;
    end
  end

  // Strobe marks every cycle in which the register is written
  assign qe = wr_en;
  // Value the flop takes at the next edge
  assign ds = wr_en ? wr_data : q;

  if (SwAccess == SwAccessRC) begin : gen_rc_read
    // On a read colliding with a hardware load, software sees the loaded
    // value while the register itself still clears
    assign qs = (we && de) ? d : q;

    // A plain read leaves the register empty
    a_rc_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (we && !de) |=> (q == '0));
  end else begin : gen_plain_read
    assign qs = q;

    // Every bit set by hardware is in the register after the edge,
    // whatever software wrote or cleared in the same cycle
    a_hw_update_lands: assert property (@(posedge clk_i) disable iff (!rst_ni)
      de |=> ((q & $past(d)) == $past(d)));
  end

endmodule

// File: src/evcnt_reg_top.sv
// Register block of the event-counter peripheral
// Decodes the simple register bus, holds the five register slices and
// returns read data one cycle after each read request
// Also forms the interrupt from state and enable
`timescale 1ns/1ns
`include "evcnt_defines.svh"

module evcnt_reg_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  evcnt_reg_pkg::bus_req_t bus_req,
  input  evcnt_reg_pkg::hw2reg_t  hw2reg,
  output evcnt_reg_pkg::reg2hw_t  reg2hw,
  output logic                   rvalid,
  output logic [`EVCNT_DW-1:0]   rdata,
  output logic                   irq
);
  import prim_subreg_pkg::*;
  import evcnt_reg_pkg::*;

  logic                 hit_ctrl;
  logic                 hit_count;
  logic                 hit_capture;
  logic                 hit_intr_state;
  logic                 hit_intr_enable;
  logic                 wr_req;
  logic                 rd_req;
  logic                 ctrl_qe;
  logic [1:0]           ctrl_ds;
  logic [1:0]           ctrl_qs;
  logic [`EVCNT_DW-1:0] count_q;
  logic [`EVCNT_DW-1:0] count_qs;
  logic [`EVCNT_DW-1:0] capture_qs;
  logic                 intr_state_q;
  logic                 intr_enable_q;
  ctrl_u                ctrl_hw;
  ctrl_u                ctrl_rd;
  logic [`EVCNT_DW-1:0] rdata_d;

  // Address decode, every other offset is unmapped
  assign hit_ctrl        = bus_req.addr == `EVCNT_AW'(`EVCNT_CTRL_OFFSET);
  assign hit_count       = bus_req.addr == `EVCNT_AW'(`EVCNT_COUNT_OFFSET);
  assign hit_capture     = bus_req.addr == `EVCNT_AW'(`EVCNT_CAPTURE_OFFSET);
  assign hit_intr_state  = bus_req.addr == `EVCNT_AW'(`EVCNT_INTR_STATE_OFFSET);
  assign hit_intr_enable = bus_req.addr == `EVCNT_AW'(`EVCNT_INTR_ENABLE_OFFSET);

  assign wr_req = bus_req.req & bus_req.we;
  assign rd_req = bus_req.req & ~bus_req.we;

  // CTRL holds enable in bit 0 and the capture request in bit 1
  prim_subreg #(.DW(2), .SwAccess(SwAccessRW), .RESVAL(2'b00)) i_ctrl (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .we (wr_req & hit_ctrl), .wd (bus_req.wdata[1:0]),
    .de (1'b0), .d (2'b00),
    .qe (ctrl_qe), .q (), .ds (ctrl_ds), .qs (ctrl_qs)
  );

  // COUNT, the core's increment beats a software write
  prim_subreg #(.DW(`EVCNT_DW), .SwAccess(SwAccessRW), .RESVAL('0)) i_count (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .we (wr_req & hit_count), .wd (bus_req.wdata),
    .de (hw2reg.count_de), .d (hw2reg.count_d),
    .qe (), .q (count_q), .ds (), .qs (count_qs)
  );

  // CAPTURE is cleared by a read, so the read strobe drives we
  prim_subreg #(.DW(`EVCNT_DW), .SwAccess(SwAccessRC), .RESVAL('0)) i_capture (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .we (rd_req & hit_capture), .wd ('0),
    .de (hw2reg.capture_de), .d (hw2reg.capture_d),
    .qe (), .q (), .ds (), .qs (capture_qs)
  );

  // Overflow status, set by the core and cleared by writing one
  prim_subreg #(.DW(1), .SwAccess(SwAccessW1C), .RESVAL(1'b0)) i_intr_state (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .we (wr_req & hit_intr_state), .wd (bus_req.wdata[0]),
    .de (hw2reg.intr_de), .d (1'b1),
    .qe (), .q (intr_state_q), .ds (), .qs ()
  );

  prim_subreg #(.DW(1), .SwAccess(SwAccessRW), .RESVAL(1'b0)) i_intr_enable (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .we (wr_req & hit_intr_enable), .wd (bus_req.wdata[0]),
    .de (1'b0), .d (1'b0),
    .qe (), .q (intr_enable_q), .ds (), .qs ()
  );

  // The core gets CTRL as it will be after this edge, so a write with the
  // capture bit is visible together with its strobe
  assign ctrl_hw.raw = {{(`EVCNT_DW-2){1'b0}}, ctrl_ds};
  // Software reads the stored word
  assign ctrl_rd.raw = {{(`EVCNT_DW-2){1'b0}}, ctrl_qs};

  assign reg2hw.ctrl       = ctrl_hw;
  assign reg2hw.ctrl_qe    = ctrl_qe;
  assign reg2hw.count      = count_q;
  assign reg2hw.intr_state = intr_state_q;

  // Read mux, unmapped offsets return zero
  always_comb begin
    rdata_d = '0;
    if (hit_ctrl) begin
      rdata_d = ctrl_rd.raw;
    end else if (hit_count) begin
      rdata_d = count_qs;
    end else if (hit_capture) begin
      rdata_d = capture_qs;
    end else if (hit_intr_state) begin
      rdata_d = {{(`EVCNT_DW-1){1'b0}}, intr_state_q};
    end else if (hit_intr_enable) begin
      rdata_d = {{(`EVCNT_DW-1){1'b0}}, intr_enable_q};
    end
  end

  // The response flag follows every read, the data is loaded only by a read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end else begin
      rvalid <= rd_req;
      if (rd_req) begin
        rdata <= rdata_d;
      end
    end
  end

  assign irq = intr_state_q & intr_enable_q;

  // The interrupt only rises after an overflow set or a write to the enable
  a_irq_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(irq) |-> $past(hw2reg.intr_de || (wr_req && hit_intr_enable)));

endmodule

// File: src/evcnt_core.sv
// Counter core of the event-counter peripheral
// Increments COUNT on enabled events, flags a wrap and requests captures
// Purely combinational, the state lives in the register slices
`timescale 1ns/1ns
`include "evcnt_defines.svh"

module evcnt_core (
  input  evcnt_reg_pkg::reg2hw_t reg2hw,
  input  logic                  event_i,
  input  logic                  capture_i,
  output evcnt_reg_pkg::hw2reg_t hw2reg
);
  import evcnt_reg_pkg::*;

  ctrl_fields_t         ctrl;
  logic                 count_inc;
  logic                 count_carry;
  logic [`EVCNT_DW-1:0] count_next;
  logic                 capture_sel;

  // Field view of CTRL
  assign ctrl = reg2hw.ctrl.fields;

  // One increment per cycle with the event level high
  assign count_inc = ctrl.enable & event_i;

  // The carry out of the adder marks a wrap from all ones to zero
  assign {count_carry, count_next} = {1'b0, reg2hw.count} + (`EVCNT_DW+1)'(1);

  assign hw2reg.count_de = count_inc;
  assign hw2reg.count_d  = count_next;

  // Overflow sets the interrupt state in the cycle of the wrap
  assign hw2reg.intr_de = count_inc & count_carry;

  // Capture on the external pulse or on a CTRL write with the capture bit
  assign capture_sel = capture_i | (reg2hw.ctrl_qe & ctrl.capture);

  // The captured value is COUNT before any increment of this cycle
  assign hw2reg.capture_de = capture_sel;
  assign hw2reg.capture_d  = reg2hw.count;

endmodule

// File: src/evcnt_top.sv
// Top level of the event-counter peripheral
// Joins the register block and the counter core
// Bus requests come in on bus_req, responses leave on rvalid and rdata
`timescale 1ns/1ns
`include "evcnt_defines.svh"

module evcnt_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  evcnt_reg_pkg::bus_req_t bus_req,
  input  logic                   event_i,
  input  logic                   capture_i,
  output logic                   rvalid,
  output logic [`EVCNT_DW-1:0]   rdata,
  output logic                   irq
);
  import evcnt_reg_pkg::*;

  // Register values towards the core and its updates back
  reg2hw_t reg2hw;
  hw2reg_t hw2reg;

  evcnt_reg_top i_evcnt_reg_top (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .bus_req (bus_req),
    .hw2reg  (hw2reg),
    .reg2hw  (reg2hw),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .irq     (irq)
  );

  evcnt_core i_evcnt_core (
    .reg2hw    (reg2hw),
    .event_i   (event_i),
    .capture_i (capture_i),
    .hw2reg    (hw2reg)
  );

endmodule

// File: verification/evcnt_checker.sv
// Register model and scoreboard of the event-counter peripheral
// Steps the model at each rising edge from the DUT inputs, then compares
// rvalid, rdata and irq at the falling edge where they are settled
`timescale 1ns/1ns
`include "evcnt_defines.svh"

module evcnt_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  evcnt_reg_pkg::bus_req_t bus_req,
  input  logic                    event_i,
  input  logic                    capture_i,
  input  logic                    rvalid,
  input  logic [`EVCNT_DW-1:0]    rdata,
  input  logic                    irq,
  output int                      error_count,
  output int                      check_count
);
  import evcnt_reg_pkg::*;

  localparam logic [`EVCNT_AW-1:0] ctrl_addr        = `EVCNT_AW'(`EVCNT_CTRL_OFFSET);
  localparam logic [`EVCNT_AW-1:0] count_addr       = `EVCNT_AW'(`EVCNT_COUNT_OFFSET);
  localparam logic [`EVCNT_AW-1:0] capture_addr     = `EVCNT_AW'(`EVCNT_CAPTURE_OFFSET);
  localparam logic [`EVCNT_AW-1:0] intr_state_addr  = `EVCNT_AW'(`EVCNT_INTR_STATE_OFFSET);
  localparam logic [`EVCNT_AW-1:0] intr_enable_addr = `EVCNT_AW'(`EVCNT_INTR_ENABLE_OFFSET);

  // Model of the five registers
  logic [1:0]           m_ctrl;
  logic [`EVCNT_DW-1:0] m_count;
  logic [`EVCNT_DW-1:0] m_capture;
  logic                 m_state;
  logic                 m_enable;
  // Response expected after the last edge
  logic                 exp_rvalid;
  logic [`EVCNT_DW-1:0] exp_rdata;
  int                   errors = 0;
  int                   checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  always @(posedge clk_i) begin : model_step
    logic       wr;
    logic       rd;
    logic       ctrl_wr;
    logic [1:0] ctrl_next;
    logic       inc;
    logic       wrap;
    logic       cap;
    logic       cap_rd;
    if (!rst_ni) begin
      m_ctrl     = '0;
      m_count    = '0;
      m_capture  = '0;
      m_state    = 1'b0;
      m_enable   = 1'b0;
      exp_rvalid = 1'b0;
    end else begin
      wr        = bus_req.req && bus_req.we;
      rd        = bus_req.req && !bus_req.we;
      ctrl_wr   = wr && bus_req.addr == ctrl_addr;
      ctrl_next = ctrl_wr ? bus_req.wdata[1:0] : m_ctrl;
      // The core sees CTRL as it stands after this edge
      inc       = ctrl_next[0] && event_i;
      wrap      = inc && m_count == '1;
      cap       = capture_i || (ctrl_wr && bus_req.wdata[1]);
      cap_rd    = rd && bus_req.addr == capture_addr;

      // Reads return the values before this edge, a colliding capture wins
      exp_rvalid = rd;
      if (rd) begin
        case (bus_req.addr)
          ctrl_addr:        exp_rdata = {{(`EVCNT_DW-2){1'b0}}, m_ctrl};
          count_addr:       exp_rdata = m_count;
          capture_addr:     exp_rdata = cap ? m_count : m_capture;
          intr_state_addr:  exp_rdata = {{(`EVCNT_DW-1){1'b0}}, m_state};
          intr_enable_addr: exp_rdata = {{(`EVCNT_DW-1){1'b0}}, m_enable};
          default:          exp_rdata = '0;
        endcase
      end

      // A read always empties CAPTURE, even when a capture lands with it
      if (cap_rd) begin
        m_capture = '0;
      end else if (cap) begin
        m_capture = m_count;
      end
      // An increment beats a software write
      if (inc) begin
        m_count = m_count + 1;
      end else if (wr && bus_req.addr == count_addr) begin
        m_count = bus_req.wdata;
      end
      if (wr && bus_req.addr == intr_state_addr) begin
        m_state = m_state & ~bus_req.wdata[0];
      end
      m_state = m_state | wrap;
      if (wr && bus_req.addr == intr_enable_addr) begin
        m_enable = bus_req.wdata[0];
      end
      m_ctrl = ctrl_next;
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni) begin
      checks++;
      if (rvalid !== exp_rvalid) begin
        errors++;
        $display("ERROR t=%0t rvalid expected %0b actual %0b", $time, exp_rvalid, rvalid);
      end else if (rvalid && rdata !== exp_rdata) begin
        errors++;
        $display("ERROR t=%0t rdata expected 0x%08h actual 0x%08h", $time, exp_rdata, rdata);
      end
      if (irq !== (m_state & m_enable)) begin
        errors++;
        $display("ERROR t=%0t irq expected %0b actual %0b", $time, m_state & m_enable, irq);
      end
    end
  end

endmodule

// File: verification/evcnt_tb.sv
// Testbench top of the event-counter peripheral
// Runs a short directed sequence, then seeded random bus traffic, event levels
// and capture pulses; evcnt_checker models the registers and flags mismatches
`timescale 1ns/1ns
`include "evcnt_defines.svh"

module evcnt_tb;
  import evcnt_reg_pkg::*;

  localparam int random_cycles = 4000;
  localparam int resp_timeout  = 20;

  localparam logic [`EVCNT_AW-1:0] ctrl_addr        = `EVCNT_AW'(`EVCNT_CTRL_OFFSET);
  localparam logic [`EVCNT_AW-1:0] count_addr       = `EVCNT_AW'(`EVCNT_COUNT_OFFSET);
  localparam logic [`EVCNT_AW-1:0] capture_addr     = `EVCNT_AW'(`EVCNT_CAPTURE_OFFSET);
  localparam logic [`EVCNT_AW-1:0] intr_state_addr  = `EVCNT_AW'(`EVCNT_INTR_STATE_OFFSET);
  localparam logic [`EVCNT_AW-1:0] intr_enable_addr = `EVCNT_AW'(`EVCNT_INTR_ENABLE_OFFSET);
  // First offset past the last register
  localparam logic [`EVCNT_AW-1:0] unmapped_addr    = `EVCNT_AW'(20);

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  bus_req_t             bus_req;
  logic                 event_i;
  logic                 capture_i;
  logic                 rvalid;
  logic [`EVCNT_DW-1:0] rdata;
  logic                 irq;
  int                   error_count;
  int                   check_count;
  int                   timeout_count;
  integer               seed;

  // 8 ns period
  always #4 clk_i = ~clk_i;

  evcnt_top i_evcnt_top (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bus_req   (bus_req),
    .event_i   (event_i),
    .capture_i (capture_i),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .irq       (irq)
  );

  evcnt_checker i_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bus_req     (bus_req),
    .event_i     (event_i),
    .capture_i   (capture_i),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .irq         (irq),
    .error_count (error_count),
    .check_count (check_count)
  );

  // Inputs change 1 ns after the rising edge, well away from sampling
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic finish_run();
    $display("Checks: %0d  Errors: %0d  Timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic bus_write(input logic [`EVCNT_AW-1:0] addr, input logic [`EVCNT_DW-1:0] data);
    bus_req.req   = 1'b1;
    bus_req.we    = 1'b1;
    bus_req.addr  = addr;
    bus_req.wdata = data;
    next_cycle();
    bus_req.req = 1'b0;
    bus_req.we  = 1'b0;
  endtask

  // Issues one read and waits for its response, the checker judges the data
  task automatic bus_read(input logic [`EVCNT_AW-1:0] addr);
    int waited;
    bus_req.req   = 1'b1;
    bus_req.we    = 1'b0;
    bus_req.addr  = addr;
    bus_req.wdata = '0;
    next_cycle();
    bus_req.req = 1'b0;
    waited = 0;
    while (!rvalid && waited < resp_timeout) begin
      next_cycle();
      waited++;
    end
    if (!rvalid) begin
      $display("Timeout: no read response for address %0d", addr);
      timeout_count++;
    end
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] data;
    logic [2:0]  slot;
    r    = $random(seed);
    data = $random(seed);
    // Slots 0 to 4 are the registers, slot 5 is unmapped
    slot = 3'(r[7:4] % 4'd6);
    if (slot == 3'd0) begin
      // Keep the counter enabled most of the time
      data[0] = r[18] | r[19];
    end else if (slot == 3'd1 && r[11:8] == 4'd0) begin
      // Now and then park COUNT close to a wrap
      data = 32'hffff_fff0 | {28'd0, data[3:0]};
    end
    bus_req.req   = r[1] | r[2];
    bus_req.we    = r[3];
    bus_req.addr  = `EVCNT_AW'({slot, 2'b00});
    bus_req.wdata = data;
    event_i       = r[12];
    capture_i     = (r[17:13] == 5'd0);
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (rvalid && waited < resp_timeout) begin
      next_cycle();
      waited++;
    end
    if (rvalid) begin
      $display("Timeout: rvalid stayed high after the last read");
      timeout_count++;
    end
  endtask

  initial begin
    seed          = 32'h254b;
    timeout_count = 0;
    rst_ni        = 1'b0;
    bus_req       = '0;
    event_i       = 1'b0;
    capture_i     = 1'b0;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk_i);
    end
    #1;
    rst_ni = 1'b1;

    // Plain read-back, then an unmapped read
    bus_write(ctrl_addr, 32'h1);
    bus_read(ctrl_addr);
    bus_write(intr_enable_addr, 32'h1);
    bus_read(intr_enable_addr);
    bus_read(unmapped_addr);

    // Let COUNT wrap a few counts below all ones
    bus_write(count_addr, 32'hffff_fffc);
    event_i = 1'b1;
    for (int i = 0; i < 6; i++) begin
      next_cycle();
    end
    event_i = 1'b0;
    bus_read(intr_state_addr);
    bus_write(intr_state_addr, 32'h1);
    bus_read(intr_state_addr);

    // Capture by pulse, the second read sees the cleared register
    capture_i = 1'b1;
    next_cycle();
    capture_i = 1'b0;
    bus_read(capture_addr);
    bus_read(capture_addr);
    // Capture pulse in the same cycle as the read
    capture_i = 1'b1;
    bus_read(capture_addr);
    capture_i = 1'b0;
    bus_read(capture_addr);
    // Capture through CTRL
    bus_write(ctrl_addr, 32'h3);
    bus_read(capture_addr);

    for (int i = 0; i < random_cycles; i++) begin
      drive_random();
      next_cycle();
    end
    bus_req.req = 1'b0;
    event_i     = 1'b0;
    capture_i   = 1'b0;
    drain_responses();
    next_cycle();
    finish_run();
  end

endmodule

// File: evcnt.f
+incdir+src
src/prim_subreg_pkg.sv
src/evcnt_reg_pkg.sv
src/prim_subreg_arb.sv
src/prim_subreg.sv
src/evcnt_reg_top.sv
src/evcnt_core.sv
src/evcnt_top.sv
verification/evcnt_checker.sv
verification/evcnt_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compiles the event-counter testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f evcnt.f --top-module evcnt_tb -Mdir obj_dir -o evcnt_sim

./obj_dir/evcnt_sim | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
